/* design/mem_pipe_pkg.sv */
package mem_pipe_pkg;

    // Basic widths
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int CSR_ADR_W = 12;
    localparam int LANES     = WORD_W / 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [CSR_ADR_W-1:0] csr_addr_t;
    typedef logic [LANES-1:0]     byte_en_t;

    // Machine mode CSR map
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;

    // Exception codes for mcause
    localparam word_t CAUSE_MAL_LOAD  = 32'd4;
    localparam word_t CAUSE_MAL_STORE = 32'd6;

    // Access width, shared by loads and stores
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        NONE
    } load_t;

    // Writeback source
    typedef enum logic [2:0] {
        WSEL_LOAD,
        WSEL_PC4,
        WSEL_IMMU,
        WSEL_ALU,
        WSEL_CSR
    } w_sel_t;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_SWAP,
        CSR_SET,
        CSR_CLR
    } csr_op_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP,
        DONE
    } axil_state_t;

    // Execute to memory pipeline register
    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      pc4;
        word_t      alu_out;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm_u;
        logic       dren;
        logic       dwen;
        load_t      load_type;
        w_sel_t     w_sel;
        logic       reg_write;
        reg_idx_t   rd;
        csr_op_t    csr_op;
        logic       csr_imm;
        logic [4:0] zimm;
        csr_addr_t  csr_addr;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        word_t    wdata;
    } wb_t;

    typedef struct packed {
        logic  valid;
        word_t cause;
        word_t tval;
    } trap_t;

    // Stage to bus master
    typedef struct packed {
        logic     req;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } dreq_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } drsp_t;

    typedef struct packed {
        csr_op_t   op;
        csr_addr_t addr;
        word_t     wdata;
        logic      trap;
        word_t     cause;
        word_t     epc;
        word_t     tval;
    } csr_req_t;

    // AXI4-Lite channels, master side outputs
    typedef struct packed {
        logic     awvalid;
        word_t    awaddr;
        logic     wvalid;
        word_t    wdata;
        byte_en_t wstrb;
        logic     arvalid;
        word_t    araddr;
        logic     bready;
        logic     rready;
    } axil_m2s_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        word_t      rdata;
        logic [1:0] rresp;
    } axil_s2m_t;

endpackage

/* design/dmem_extender.sv */
`timescale 1ns/1ps

module dmem_extender (
    input  mem_pipe_pkg::word_t dmem_in,
    input  mem_pipe_pkg::load_t load_type,
    input  logic [1:0]          byte_offset,
    output mem_pipe_pkg::word_t ext_out
);

    import mem_pipe_pkg::*;

    word_t shifted;

    // Bring the addressed lane down to bit 0
    assign shifted = dmem_in >> {byte_offset, 3'b000};

    always_comb begin
        case (load_type)
            LB: begin
                ext_out = {{24{shifted[7]}}, shifted[7:0]};
            end
            LBU: begin
                ext_out = {24'h0, shifted[7:0]};
            end
            LH: begin
                ext_out = {{16{shifted[15]}}, shifted[15:0]};
            end
            LHU: begin
                ext_out = {16'h0, shifted[15:0]};
            end
            // Full word needs no lane select
            LW: begin
                ext_out = dmem_in;
            end
            default: begin
                ext_out = '0;
            end
        endcase
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  mem_pipe_pkg::ex_mem_t  ex_mem,
    output mem_pipe_pkg::dreq_t    dreq,
    input  mem_pipe_pkg::drsp_t    drsp,
    input  mem_pipe_pkg::word_t    load_word,
    output mem_pipe_pkg::csr_req_t csr_req,
    input  mem_pipe_pkg::word_t    csr_rdata,
    output logic                   stall,
    output mem_pipe_pkg::wb_t      wb,
    output mem_pipe_pkg::trap_t    trap
);

    import mem_pipe_pkg::*;

    logic       mem_access;
    logic       mal_addr;
    logic       mal_access;
    logic       retire;
    logic [1:0] byte_offset;
    byte_en_t   byte_en;
    word_t      store_data;
    word_t      wdata_sel;

    assign byte_offset = ex_mem.alu_out[1:0];
    assign mem_access  = ex_mem.dren || ex_mem.dwen;

    // Lane mask from width and low address bits
    always_comb begin
        case (ex_mem.load_type)
            LB, LBU: begin
                byte_en = byte_en_t'(4'b0001 << byte_offset);
            end
            LH, LHU: begin
                case (byte_offset)
                    2'b00:   byte_en = 4'b0011;
                    2'b10:   byte_en = 4'b1100;
                    default: byte_en = 4'b0000;
                endcase
            end
            LW: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    // Words need 4-byte alignment, halfwords an even address
    always_comb begin
        case (ex_mem.load_type)
            LW:      mal_addr = (byte_offset != 2'b00);
            LH, LHU: mal_addr = byte_offset[0];
            default: mal_addr = 1'b0;
        endcase
    end

    assign mal_access = ex_mem.valid && mem_access && mal_addr;

    // Store data copied into every lane, wstrb picks the live ones
    always_comb begin
        case (ex_mem.load_type)
            LB:      store_data = {4{ex_mem.rs2_data[7:0]}};
            LH:      store_data = {2{ex_mem.rs2_data[15:0]}};
            LW:      store_data = ex_mem.rs2_data;
            default: store_data = '0;
        endcase
    end

    // Only aligned accesses go out on the bus
    assign dreq.req     = ex_mem.valid && mem_access && !mal_addr;
    assign dreq.wen     = ex_mem.dwen;
    assign dreq.addr    = ex_mem.alu_out;
    assign dreq.wdata   = store_data;
    assign dreq.byte_en = byte_en;

    assign stall  = dreq.req && !drsp.done;
    assign retire = ex_mem.valid && !stall;

    // Trap report for misaligned load or store
    assign trap.valid = mal_access;
    assign trap.cause = ex_mem.dren ? CAUSE_MAL_LOAD : CAUSE_MAL_STORE;
    assign trap.tval  = ex_mem.alu_out;

    // CSR side, write only on the retiring cycle
    assign csr_req.op    = retire ? ex_mem.csr_op : CSR_NONE;
    assign csr_req.addr  = ex_mem.csr_addr;
    assign csr_req.wdata = ex_mem.csr_imm ? {27'h0, ex_mem.zimm} : ex_mem.rs1_data;
    assign csr_req.trap  = trap.valid;
    assign csr_req.cause = trap.cause;
    assign csr_req.epc   = ex_mem.pc;
    assign csr_req.tval  = trap.tval;

    // Writeback value
    always_comb begin
        case (ex_mem.w_sel)
            WSEL_LOAD: wdata_sel = load_word;
            WSEL_PC4:  wdata_sel = ex_mem.pc4;
            WSEL_IMMU: wdata_sel = ex_mem.imm_u;
            WSEL_ALU:  wdata_sel = ex_mem.alu_out;
            WSEL_CSR:  wdata_sel = csr_rdata;
            default:   wdata_sel = '0;
        endcase
    end

    assign wb.valid     = retire;
    // A trapping access must not write rd
    assign wb.reg_write = retire && ex_mem.reg_write && !mal_access;
    assign wb.rd        = ex_mem.rd;
    assign wb.wdata     = wdata_sel;

endmodule

/* design/axil_data_master.sv */
`timescale 1ns/1ps

module axil_data_master (
    input  logic                    CLK,
    input  logic                    nRST,
    input  mem_pipe_pkg::dreq_t     dreq,
    output mem_pipe_pkg::drsp_t     drsp,
    output mem_pipe_pkg::axil_m2s_t axil_out,
    input  mem_pipe_pkg::axil_s2m_t axil_in
);

    import mem_pipe_pkg::*;

    axil_state_t state;
    axil_state_t state_next;
    logic        aw_done;
    logic        w_done;
    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;
    logic        b_hs;
    logic        r_hs;
    logic        wen_q;
    word_t       addr_q;
    word_t       wdata_q;
    word_t       rdata_q;
    byte_en_t    strb_q;

    assign aw_hs = axil_out.awvalid && axil_in.awready;
    assign w_hs  = axil_out.wvalid && axil_in.wready;
    assign ar_hs = axil_out.arvalid && axil_in.arready;
    assign b_hs  = axil_out.bready && axil_in.bvalid;
    assign r_hs  = axil_out.rready && axil_in.rvalid;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (dreq.req) begin
                    state_next = ADDR;
                end
            end
            ADDR: begin
                // Write waits for both AW and W, in either order
                if (wen_q) begin
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        state_next = RESP;
                    end
                end else if (ar_hs) begin
                    state_next = RESP;
                end
            end
            RESP: begin
                if (b_hs || r_hs) begin
                    state_next = DONE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_next;
            if (state == IDLE) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                aw_done <= aw_done || aw_hs;
                w_done  <= w_done || w_hs;
            end
        end
    end

    // Request captured once so the payload holds while valid waits
    always_ff @(posedge CLK) begin
        if (state == IDLE && dreq.req) begin
            wen_q   <= dreq.wen;
            addr_q  <= dreq.addr;
            wdata_q <= dreq.wdata;
            strb_q  <= dreq.byte_en;
        end
        if (r_hs) begin
            rdata_q <= axil_in.rdata;
        end
    end

    assign axil_out.awvalid = (state == ADDR) && wen_q && !aw_done;
    assign axil_out.awaddr  = addr_q;
    assign axil_out.wvalid  = (state == ADDR) && wen_q && !w_done;
    assign axil_out.wdata   = wdata_q;
    assign axil_out.wstrb   = strb_q;
    assign axil_out.arvalid = (state == ADDR) && !wen_q;
    assign axil_out.araddr  = addr_q;
    assign axil_out.bready  = (state == RESP) && wen_q;
    assign axil_out.rready  = (state == RESP) && !wen_q;

    // bresp and rresp are not checked
    assign drsp.done  = (state == DONE);
    assign drsp.rdata = rdata_q;

endmodule

/* design/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
    input  logic                   CLK,
    input  logic                   nRST,
    input  mem_pipe_pkg::csr_req_t csr_req,
    output mem_pipe_pkg::word_t    rdata
);

    import mem_pipe_pkg::*;

    word_t mscratch;
    word_t mtvec;
    word_t mepc;
    word_t mcause;
    word_t mtval;
    word_t csr_new;

    // Read port, unknown addresses return zero
    always_comb begin
        case (csr_req.addr)
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MTVEC:    rdata = mtvec;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE:   rdata = mcause;
            CSR_MTVAL:    rdata = mtval;
            default:      rdata = '0;
        endcase
    end

    // Read-modify-write value
    always_comb begin
        case (csr_req.op)
            CSR_SWAP: csr_new = csr_req.wdata;
            CSR_SET:  csr_new = rdata | csr_req.wdata;
            CSR_CLR:  csr_new = rdata & ~csr_req.wdata;
            default:  csr_new = rdata;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (csr_req.trap) begin
            // Trap capture wins over any CSR write
            mepc   <= csr_req.epc;
            mcause <= csr_req.cause;
            mtval  <= csr_req.tval;
        end else if (csr_req.op != CSR_NONE) begin
            case (csr_req.addr)
                CSR_MSCRATCH: mscratch <= csr_new;
                CSR_MTVEC:    mtvec    <= csr_new;
                CSR_MEPC:     mepc     <= csr_new;
                CSR_MCAUSE:   mcause   <= csr_new;
                CSR_MTVAL:    mtval    <= csr_new;
                default:      mscratch <= mscratch;
            endcase
        end
    end

endmodule

/* design/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                    CLK,
    input  logic                    nRST,
    input  mem_pipe_pkg::ex_mem_t   ex_mem,
    output logic                    stall,
    output mem_pipe_pkg::wb_t       wb,
    output mem_pipe_pkg::trap_t     trap,
    output mem_pipe_pkg::axil_m2s_t axil_out,
    input  mem_pipe_pkg::axil_s2m_t axil_in
);

    import mem_pipe_pkg::*;

    dreq_t    dreq;
    drsp_t    drsp;
    csr_req_t csr_req;
    word_t    csr_rdata;
    word_t    load_word;

    mem_stage u_mem_stage (
        .ex_mem    (ex_mem),
        .dreq      (dreq),
        .drsp      (drsp),
        .load_word (load_word),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .stall     (stall),
        .wb        (wb),
        .trap      (trap)
    );

    // Load data straight from the registered bus response
    dmem_extender u_dmem_extender (
        .dmem_in     (drsp.rdata),
        .load_type   (ex_mem.load_type),
        .byte_offset (ex_mem.alu_out[1:0]),
        .ext_out     (load_word)
    );

    axil_data_master u_axil_data_master (
        .CLK      (CLK),
        .nRST     (nRST),
        .dreq     (dreq),
        .drsp     (drsp),
        .axil_out (axil_out),
        .axil_in  (axil_in)
    );

    csr_unit u_csr_unit (
        .CLK     (CLK),
        .nRST    (nRST),
        .csr_req (csr_req),
        .rdata   (csr_rdata)
    );

endmodule

/* tb/mem_ref_model.svh */
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// One model word per 4 bytes of the 256-byte data window
word_t model_mem [0:63];
word_t m_mscratch;
word_t m_mtvec;
word_t m_mepc;
word_t m_mcause;
word_t m_mtval;

function automatic void reset_csr_model();
    m_mscratch = '0;
    m_mtvec    = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
endfunction

// Words need 4-byte alignment, halfwords an even address
function automatic logic is_misaligned(word_t addr, load_t lt);
    case (lt)
        LW:      return addr[1:0] != 2'b00;
        LH, LHU: return addr[0];
        default: return 1'b0;
    endcase
endfunction

function automatic word_t load_value(word_t addr, load_t lt);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    int          off;
    w   = model_mem[addr[7:2]];
    off = int'(addr[1:0]);
    b   = w[8*off +: 8];
    h   = addr[1] ? w[31:16] : w[15:0];
    case (lt)
        LB:      return {{24{b[7]}}, b};
        LBU:     return {24'h0, b};
        LH:      return {{16{h[15]}}, h};
        LHU:     return {16'h0, h};
        default: return w;
    endcase
endfunction

// Only the addressed lanes change
function automatic void store_value(word_t addr, word_t data, load_t lt);
    int off;
    off = int'(addr[1:0]);
    case (lt)
        LB:      model_mem[addr[7:2]][8*off +: 8] = data[7:0];
        LH:      model_mem[addr[7:2]][8*off +: 16] = data[15:0];
        default: model_mem[addr[7:2]] = data;
    endcase
endfunction

function automatic word_t read_csr(csr_addr_t addr);
    case (addr)
        CSR_MSCRATCH: return m_mscratch;
        CSR_MTVEC:    return m_mtvec;
        CSR_MEPC:     return m_mepc;
        CSR_MCAUSE:   return m_mcause;
        CSR_MTVAL:    return m_mtval;
        default:      return '0;
    endcase
endfunction

function automatic void update_csr(csr_op_t op, csr_addr_t addr, word_t src);
    word_t nv;
    case (op)
        CSR_SWAP: nv = src;
        CSR_SET:  nv = read_csr(addr) | src;
        default:  nv = read_csr(addr) & ~src;
    endcase
    case (addr)
        CSR_MSCRATCH: m_mscratch = nv;
        CSR_MTVEC:    m_mtvec    = nv;
        CSR_MEPC:     m_mepc     = nv;
        CSR_MCAUSE:   m_mcause   = nv;
        CSR_MTVAL:    m_mtval    = nv;
        default:      m_mscratch = m_mscratch;
    endcase
endfunction

function automatic void capture_trap(word_t epc, word_t cause, word_t tval);
    m_mepc   = epc;
    m_mcause = cause;
    m_mtval  = tval;
endfunction

`endif

/* tb/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

    import mem_pipe_pkg::*;

    localparam int    N_INSTR    = 2000;
    localparam int    TIMEOUT_NS = N_INSTR * 10 * 10 + 20 * 10;
    localparam word_t BASE_ADDR  = 32'h0000_2000;

    logic      CLK = 1'b0;
    logic      nRST;
    ex_mem_t   ex_mem;
    logic      stall;
    wb_t       wb;
    trap_t     trap;
    axil_m2s_t axil_out;
    axil_s2m_t axil_in;
    int        seed = 58347;
    word_t     axi_mem [0:63];

    `include "mem_ref_model.svh"

    mem_subsystem dut0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .ex_mem   (ex_mem),
        .stall    (stall),
        .wb       (wb),
        .trap     (trap),
        .axil_out (axil_out),
        .axil_in  (axil_in)
    );

    always #5 CLK = ~CLK;

    function automatic word_t next_random();
        return $random(seed);
    endfunction

    function automatic int pick_below(int n);
        return int'({$random(seed)} % n);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got.valid !== exp.valid || got.reg_write !== exp.reg_write ||
            (exp.reg_write && (got.rd !== exp.rd || got.wdata !== exp.wdata))) begin
            abort_run($sformatf(
                "ERR %0t: wb got v=%0b we=%0b rd=%0d %h, exp v=%0b we=%0b rd=%0d %h",
                $time, got.valid, got.reg_write, got.rd, got.wdata,
                exp.valid, exp.reg_write, exp.rd, exp.wdata));
        end
    endtask

    task automatic check_trap(input trap_t got, input trap_t exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.cause !== exp.cause || got.tval !== exp.tval))) begin
            abort_run($sformatf(
                "ERR %0t: trap got v=%0b cause=%0d tval=%h, exp v=%0b cause=%0d tval=%h",
                $time, got.valid, got.cause, got.tval, exp.valid, exp.cause, exp.tval));
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: stall got %0b, exp %0b", $time, got, exp));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: memory word %0d got %h, exp %h", $time, idx, got, exp));
        end
    endtask

    // Random 0 to 3 cycle delay that restarts once cnt goes negative
    task automatic count_delay(inout int cnt, output logic fire);
        if (cnt < 0) begin
            cnt = pick_below(4);
        end
        fire = (cnt == 0);
        cnt  = fire ? -1 : cnt - 1;
    endtask

    task automatic write_axi_mem(input word_t addr, input word_t data, input byte_en_t strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                axi_mem[addr[7:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    function automatic csr_addr_t pick_csr_addr();
        case (pick_below(6))
            0:       return CSR_MSCRATCH;
            1:       return CSR_MTVEC;
            2:       return CSR_MEPC;
            3:       return CSR_MCAUSE;
            4:       return CSR_MTVAL;
            default: return 12'h7C0;
        endcase
    endfunction

    function automatic load_t pick_load_type(int n);
        case (pick_below(n))
            0:       return LB;
            1:       return LH;
            2:       return LW;
            3:       return LBU;
            default: return LHU;
        endcase
    endfunction

    task automatic gen_instr(output ex_mem_t ins);
        int kind;
        int off;
        kind          = pick_below(8);
        ins           = '0;
        ins.valid     = 1'b1;
        ins.pc        = next_random() & ~32'h3;
        ins.pc4       = ins.pc + 32'd4;
        ins.alu_out   = next_random();
        ins.rs1_data  = next_random();
        ins.rs2_data  = next_random();
        ins.imm_u     = next_random() & 32'hFFFF_F000;
        ins.rd        = reg_idx_t'(pick_below(32));
        ins.zimm      = 5'(pick_below(32));
        ins.load_type = NONE;
        ins.w_sel     = WSEL_ALU;
        ins.csr_op    = CSR_NONE;
        ins.csr_addr  = pick_csr_addr();
        case (kind)
            0, 1: begin
                ins.dren      = 1'b1;
                ins.reg_write = 1'b1;
                ins.w_sel     = WSEL_LOAD;
                ins.load_type = pick_load_type(5);
            end
            2, 3: begin
                ins.dwen      = 1'b1;
                ins.load_type = pick_load_type(3);
            end
            4, 5: begin
                case (pick_below(3))
                    0:       ins.csr_op = CSR_SWAP;
                    1:       ins.csr_op = CSR_SET;
                    default: ins.csr_op = CSR_CLR;
                endcase
                ins.csr_imm   = (pick_below(2) == 1);
                ins.w_sel     = WSEL_CSR;
                ins.reg_write = 1'b1;
            end
            6: begin
                // csrrs with zero source reads back trap state
                ins.csr_op    = CSR_SET;
                ins.csr_imm   = 1'b1;
                ins.zimm      = 5'd0;
                ins.w_sel     = WSEL_CSR;
                ins.reg_write = 1'b1;
                ins.csr_addr  = CSR_MEPC + csr_addr_t'(pick_below(3));
            end
            default: begin
                case (pick_below(3))
                    0:       ins.w_sel = WSEL_PC4;
                    1:       ins.w_sel = WSEL_IMMU;
                    default: ins.w_sel = WSEL_ALU;
                endcase
                ins.reg_write = 1'b1;
            end
        endcase
        if (ins.dren || ins.dwen) begin
            off = pick_below(256);
            // A quarter of accesses keep the raw offset and may be misaligned
            if (pick_below(4) != 0) begin
                if (ins.load_type == LW) begin
                    off = off - off % 4;
                end else if (ins.load_type == LH || ins.load_type == LHU) begin
                    off = off - off % 2;
                end
            end
            ins.alu_out = BASE_ADDR + word_t'(off);
        end
    endtask

    task automatic expect_result(input ex_mem_t ins, output wb_t ewb, output trap_t etrap);
        logic mal;
        mal           = (ins.dren || ins.dwen) && is_misaligned(ins.alu_out, ins.load_type);
        etrap.valid   = mal;
        etrap.cause   = ins.dren ? CAUSE_MAL_LOAD : CAUSE_MAL_STORE;
        etrap.tval    = ins.alu_out;
        ewb.valid     = 1'b1;
        ewb.reg_write = ins.reg_write && !mal;
        ewb.rd        = ins.rd;
        case (ins.w_sel)
            WSEL_LOAD: ewb.wdata = load_value(ins.alu_out, ins.load_type);
            WSEL_PC4:  ewb.wdata = ins.pc4;
            WSEL_IMMU: ewb.wdata = ins.imm_u;
            WSEL_ALU:  ewb.wdata = ins.alu_out;
            default:   ewb.wdata = read_csr(ins.csr_addr);
        endcase
    endtask

    task automatic apply_effects(input ex_mem_t ins, input trap_t etrap);
        word_t src;
        src = ins.csr_imm ? {27'h0, ins.zimm} : ins.rs1_data;
        if (etrap.valid) begin
            capture_trap(ins.pc, etrap.cause, etrap.tval);
        end else begin
            if (ins.dwen) begin
                store_value(ins.alu_out, ins.rs2_data, ins.load_type);
            end
            if (ins.csr_op != CSR_NONE) begin
                update_csr(ins.csr_op, ins.csr_addr, src);
            end
        end
    endtask

    // Entered 1 ns after a rising edge and returns at the same point
    task automatic run_instr(input int n);
        ex_mem_t ins;
        wb_t     exp_wb;
        trap_t   exp_trap;
        logic    needs_bus;
        int      waited;
        gen_instr(ins);
        expect_result(ins, exp_wb, exp_trap);
        needs_bus = (ins.dren || ins.dwen) && !exp_trap.valid;
        ex_mem    = ins;
        waited    = 0;
        @(negedge CLK);
        while (!wb.valid) begin
            if (!needs_bus) begin
                abort_run($sformatf("instruction %0d did not retire when presented", n));
            end
            check_stall(stall, 1'b1);
            waited++;
            @(negedge CLK);
        end
        if (needs_bus && waited == 0) begin
            abort_run($sformatf("memory instruction %0d retired without a stall", n));
        end
        check_stall(stall, 1'b0);
        check_wb(wb, exp_wb);
        check_trap(trap, exp_trap);
        apply_effects(ins, exp_trap);
        @(posedge CLK);
        #1;
    endtask

    // AXI4-Lite slave that samples handshakes mid-cycle and drives 2 ns after the edge
    initial begin : axil_responder
        logic     hs_aw;
        logic     hs_w;
        logic     hs_ar;
        logic     hs_b;
        logic     hs_r;
        logic     fire;
        logic     got_aw;
        logic     got_w;
        logic     b_pend;
        logic     r_pend;
        word_t    aw_addr;
        word_t    w_data;
        word_t    ar_addr;
        byte_en_t w_strb;
        int       aw_cnt;
        int       w_cnt;
        int       ar_cnt;
        int       b_cnt;
        int       r_cnt;
        axil_in = '0;
        got_aw  = 1'b0;
        got_w   = 1'b0;
        b_pend  = 1'b0;
        r_pend  = 1'b0;
        aw_cnt  = -1;
        w_cnt   = -1;
        ar_cnt  = -1;
        b_cnt   = -1;
        r_cnt   = -1;
        forever begin
            @(negedge CLK);
            hs_aw = axil_out.awvalid && axil_in.awready;
            hs_w  = axil_out.wvalid && axil_in.wready;
            hs_ar = axil_out.arvalid && axil_in.arready;
            hs_b  = axil_out.bready && axil_in.bvalid;
            hs_r  = axil_out.rready && axil_in.rvalid;
            if (hs_aw) begin
                aw_addr = axil_out.awaddr;
            end
            if (hs_w) begin
                w_data = axil_out.wdata;
                w_strb = axil_out.wstrb;
            end
            if (hs_ar) begin
                ar_addr = axil_out.araddr;
            end
            @(posedge CLK);
            #2;
            if (hs_aw) begin
                axil_in.awready = 1'b0;
                got_aw          = 1'b1;
            end
            if (hs_w) begin
                axil_in.wready = 1'b0;
                got_w          = 1'b1;
            end
            if (got_aw && got_w) begin
                write_axi_mem(aw_addr, w_data, w_strb);
                got_aw        = 1'b0;
                got_w         = 1'b0;
                b_pend        = 1'b1;
                // Any response code, the master ignores it
                axil_in.bresp = 2'(pick_below(4));
            end
            if (hs_b) begin
                axil_in.bvalid = 1'b0;
            end
            if (hs_ar) begin
                axil_in.arready = 1'b0;
                axil_in.rdata   = axi_mem[ar_addr[7:2]];
                axil_in.rresp   = 2'(pick_below(4));
                r_pend          = 1'b1;
            end
            if (hs_r) begin
                axil_in.rvalid = 1'b0;
            end
            if (axil_out.awvalid && !axil_in.awready) begin
                count_delay(aw_cnt, fire);
                axil_in.awready = fire;
            end
            if (axil_out.wvalid && !axil_in.wready) begin
                count_delay(w_cnt, fire);
                axil_in.wready = fire;
            end
            if (axil_out.arvalid && !axil_in.arready) begin
                count_delay(ar_cnt, fire);
                axil_in.arready = fire;
            end
            if (b_pend && !axil_in.bvalid) begin
                count_delay(b_cnt, fire);
                axil_in.bvalid = fire;
                b_pend         = !fire;
            end
            if (r_pend && !axil_in.rvalid) begin
                count_delay(r_cnt, fire);
                axil_in.rvalid = fire;
                r_pend         = !fire;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        abort_run("timeout: instructions did not retire");
    end

    initial begin : main_seq
        word_t w;
        ex_mem = '0;
        nRST   = 1'b0;
        reset_csr_model();
        // Same random contents in the bus memory and the model
        for (int i = 0; i < 64; i++) begin
            w            = next_random();
            model_mem[i] = w;
            axi_mem[i]   = w;
        end
        repeat (9) @(posedge CLK);
        @(negedge CLK);
        if (stall || wb.valid || trap.valid || axil_out.awvalid || axil_out.wvalid ||
            axil_out.arvalid || axil_out.bready || axil_out.rready) begin
            abort_run("outputs are not idle during reset");
        end
        @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            run_instr(n);
        end
        for (int i = 0; i < 64; i++) begin
            check_word(axi_mem[i], model_mem[i], i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* mem_subsystem.f */
+incdir+tb
design/mem_pipe_pkg.sv
design/dmem_extender.sv
design/mem_stage.sv
design/axil_data_master.sv
design/csr_unit.sv
design/mem_subsystem.sv
tb/tb_mem_subsystem.sv

/* Makefile */
TOP  := tb_mem_subsystem
SRCS := mem_subsystem.f $(wildcard design/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing --top-module $(TOP) -f mem_subsystem.f

# Passes only when the pass line appears in the output
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
